/* logic/lsq_pkg.sv */
package lsq_pkg;

    // data path and operand width
    localparam int xlen = 32;

    // reorder buffer tag width
    localparam int rob_tag_w = 5;

    // signed immediate width, sign extended by the unit
    localparam int imm_w = 12;

    // memory operation kind
    typedef enum logic {
        ls_load  = 1'b0,
        ls_store = 1'b1
    } ls_func_e;

    // one memory instruction as handed over by dispatch
    typedef struct packed {
        // completion is reported under this tag, loads included
        logic [rob_tag_w-1:0] insn_tag;
        ls_func_e             func;
        logic [imm_w-1:0]     imm;

        // base register operand
        logic [rob_tag_w-1:0] tag_src1;
        logic                 ready_src1;
        logic [xlen-1:0]      value_src1;

        // store data operand, don't care for loads
        logic [rob_tag_w-1:0] tag_src2;
        logic                 ready_src2;
        logic [xlen-1:0]      value_src2;
    } ls_insn_t;

    // one slot of the load/store queue
    typedef struct packed {
        ls_insn_t insn;

        // slot holds a live instruction
        logic     valid;

        // commit seen for this store tag, may arrive before the store
        // reaches the head of the queue
        logic     committed;

        // sent to the unit, waiting for done
        logic     issued;
    } lsq_entry_t;

endpackage

/* logic/lsq_issue_if.sv */
`timescale 1ns/1ps

interface lsq_issue_if import lsq_pkg::*; ();

    // head operation offered by the queue, issue is a single cycle pulse
    logic     issue;
    ls_insn_t op;

    // unit status, busy from issue until the edge after done
    logic     busy;
    logic     done;

    modport queue (
        output issue,
        output op,
        input  busy,
        input  done
    );

    modport unit (
        input  issue,
        input  op,
        output busy,
        output done
    );

endinterface

/* logic/ls_queue.sv */
`timescale 1ns/1ps

module ls_queue import lsq_pkg::*; #(
    parameter int lsq_depth = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 dispatch,
    input  ls_insn_t             insn_in,
    input  logic                 commit_store,
    input  logic [rob_tag_w-1:0] commit_tag,
    input  logic                 wake_valid,
    input  logic [rob_tag_w-1:0] wake_tag,
    input  logic [xlen-1:0]      wake_data,
    output logic                 full,
    lsq_issue_if.queue           issue_port
);

    localparam int idx_w = $clog2(lsq_depth);

    lsq_entry_t       slots [lsq_depth];
    lsq_entry_t       slots_next [lsq_depth];

    // pointers carry one wrap bit above the slot index
    logic [idx_w:0]   head;
    logic [idx_w:0]   tail;
    logic [idx_w:0]   head_next;
    logic [idx_w:0]   tail_next;
    logic [idx_w-1:0] head_idx;
    logic [idx_w-1:0] tail_idx;

    lsq_entry_t       head_slot;
    logic             head_ready;
    logic             new_committed;

    // capture a broadcast result into any source still waiting on it
    // both sources may match the same broadcast
    function automatic ls_insn_t apply_wake(
        ls_insn_t             insn,
        logic                 bc_valid,
        logic [rob_tag_w-1:0] bc_tag,
        logic [xlen-1:0]      bc_data
    );
        ls_insn_t res;
        res = insn;
        if (bc_valid && !insn.ready_src1 && insn.tag_src1 == bc_tag) begin
            res.ready_src1 = 1'b1;
            res.value_src1 = bc_data;
        end
        if (bc_valid && !insn.ready_src2 && insn.tag_src2 == bc_tag) begin
            res.ready_src2 = 1'b1;
            res.value_src2 = bc_data;
        end
        return res;
    endfunction

    assign head_idx  = head[idx_w-1:0];
    assign tail_idx  = tail[idx_w-1:0];
    assign head_slot = slots[head_idx];

    // same index, different lap
    assign full = (head[idx_w] != tail[idx_w]) && (head_idx == tail_idx);

    // loads need the base only, stores also need data and commit
    always_comb begin
        head_ready = head_slot.valid && !head_slot.issued && head_slot.insn.ready_src1;
        if (head_slot.insn.func == ls_store) begin
            head_ready = head_ready && head_slot.insn.ready_src2 && head_slot.committed;
        end
    end

    assign issue_port.issue = head_ready && !issue_port.busy;
    assign issue_port.op    = head_slot.insn;

    // a commit in the dispatch cycle still counts for the new store
    assign new_committed = commit_store && insn_in.func == ls_store &&
                           insn_in.insn_tag == commit_tag;

    always_comb begin
        slots_next = slots;
        head_next  = head;
        tail_next  = tail;

        // wakeup and commit tracking across all live slots
        for (int i = 0; i < lsq_depth; i++) begin
            if (slots[i].valid) begin
                slots_next[i].insn = apply_wake(slots[i].insn, wake_valid, wake_tag, wake_data);
                if (commit_store && slots[i].insn.func == ls_store &&
                    slots[i].insn.insn_tag == commit_tag) begin
                    slots_next[i].committed = 1'b1;
                end
            end
        end

        if (issue_port.issue) begin
            slots_next[head_idx].issued = 1'b1;
        end

        // retire head once the unit reports it finished
        if (issue_port.done) begin
            slots_next[head_idx].valid     = 1'b0;
            slots_next[head_idx].issued    = 1'b0;
            slots_next[head_idx].committed = 1'b0;
            head_next = head + 1'b1;
        end

        // dispatch while full is dropped
        if (dispatch && !full) begin
            slots_next[tail_idx].insn      = apply_wake(insn_in, wake_valid, wake_tag,
                                                        wake_data);
            slots_next[tail_idx].valid     = 1'b1;
            slots_next[tail_idx].committed = new_committed;
            slots_next[tail_idx].issued    = 1'b0;
            tail_next = tail + 1'b1;
        end
    end

    // flush drops every slot in one cycle, payload is left as is
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < lsq_depth; i++) begin
                slots[i].valid     <= 1'b0;
                slots[i].committed <= 1'b0;
                slots[i].issued    <= 1'b0;
            end
        end else begin
            head  <= head_next;
            tail  <= tail_next;
            slots <= slots_next;
        end
    end

endmodule

/* logic/ls_unit.sv */
`timescale 1ns/1ps

module ls_unit import lsq_pkg::*; #(
    parameter  int mem_words = 64,
    localparam int addr_w    = $clog2(mem_words)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    lsq_issue_if.unit            issue_port,
    output logic [addr_w-1:0]    mem_addr,
    output logic [xlen-1:0]      mem_wdata,
    output logic                 mem_we,
    input  logic [xlen-1:0]      mem_rdata,
    output logic                 load_done,
    output logic                 store_done,
    output logic [rob_tag_w-1:0] done_tag,
    output logic [xlen-1:0]      load_data
);

    logic [xlen-1:0]      imm_ext;
    logic [xlen-1:0]      eff_addr;

    // stage 1, address and store data
    logic                 s1_valid;
    ls_func_e             s1_func;
    logic [rob_tag_w-1:0] s1_tag;
    logic [addr_w-1:0]    s1_addr;
    logic [xlen-1:0]      s1_wdata;

    // stage 2, memory result and completion
    logic                 s2_valid;
    ls_func_e             s2_func;
    logic [rob_tag_w-1:0] s2_tag;

    assign imm_ext  = {{(xlen-imm_w){issue_port.op.imm[imm_w-1]}}, issue_port.op.imm};
    assign eff_addr = issue_port.op.value_src1 + imm_ext;

    // flush kills an operation that has not reached memory yet
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_port.issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_port.issue) begin
            s1_func  <= issue_port.op.func;
            s1_tag   <= issue_port.op.insn_tag;
            s1_addr  <= addr_w'(eff_addr % mem_words);
            s1_wdata <= issue_port.op.value_src2;
        end
    end

    // memory sees the access on the edge into stage 2
    assign mem_addr  = s1_addr;
    assign mem_wdata = s1_wdata;
    assign mem_we    = s1_valid && !flush && s1_func == ls_store;

    always_ff @(posedge clk) begin
        if (rst) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        s2_func <= s1_func;
        s2_tag  <= s1_tag;
    end

    assign load_done  = s2_valid && s2_func == ls_load;
    assign store_done = s2_valid && s2_func == ls_store;
    assign done_tag   = s2_tag;
    assign load_data  = mem_rdata;

    // one operation in flight at a time
    assign issue_port.busy = s1_valid || s2_valid;
    assign issue_port.done = s2_valid;

endmodule

/* logic/data_mem.sv */
`timescale 1ns/1ps

module data_mem import lsq_pkg::*; #(
    parameter  int mem_words = 64,
    localparam int addr_w    = $clog2(mem_words)
) (
    input  logic              clk,
    input  logic [addr_w-1:0] addr,
    input  logic [xlen-1:0]   wdata,
    input  logic              we,
    output logic [xlen-1:0]   rdata
);

    logic [xlen-1:0] mem [mem_words];

    // loads ahead of any store return zero
    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // registered read, old contents on a same cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

/* logic/lsq_top.sv */
`timescale 1ns/1ps

module lsq_top import lsq_pkg::*; #(
    parameter int lsq_depth = 8,
    parameter int mem_words = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 dispatch,
    input  ls_insn_t             insn_in,
    input  logic                 commit_store,
    input  logic [rob_tag_w-1:0] commit_tag,
    input  logic                 wake_valid,
    input  logic [rob_tag_w-1:0] wake_tag,
    input  logic [xlen-1:0]      wake_data,
    output logic                 full,
    output logic                 load_done,
    output logic                 store_done,
    output logic [rob_tag_w-1:0] done_tag,
    output logic [xlen-1:0]      load_data
);

    localparam int addr_w = $clog2(mem_words);

    // unit to memory
    logic [addr_w-1:0] mem_addr;
    logic [xlen-1:0]   mem_wdata;
    logic              mem_we;
    logic [xlen-1:0]   mem_rdata;

    lsq_issue_if u_issue_if ();

    ls_queue #(
        .lsq_depth (lsq_depth)
    ) u_ls_queue (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .dispatch     (dispatch),
        .insn_in      (insn_in),
        .commit_store (commit_store),
        .commit_tag   (commit_tag),
        .wake_valid   (wake_valid),
        .wake_tag     (wake_tag),
        .wake_data    (wake_data),
        .full         (full),
        .issue_port   (u_issue_if.queue)
    );

    ls_unit #(
        .mem_words (mem_words)
    ) u_ls_unit (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .issue_port (u_issue_if.unit),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .mem_rdata  (mem_rdata),
        .load_done  (load_done),
        .store_done (store_done),
        .done_tag   (done_tag),
        .load_data  (load_data)
    );

    data_mem #(
        .mem_words (mem_words)
    ) u_data_mem (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

endmodule

/* dv/tb_lsq.sv */
`timescale 1ns/1ps

module tb_lsq import lsq_pkg::*; ();

    localparam int depth       = 8;
    localparam int n_rand      = 24;
    // random ops plus the directed commit, wakeup, full, flush and post-flush ops
    localparam int n_ops       = n_rand + 33;
    localparam int cycle_limit = 40 * n_ops + 200;

    logic                 clk;
    logic                 rst;
    logic                 flush;
    logic                 dispatch;
    ls_insn_t             insn_in;
    logic                 commit_store;
    logic [rob_tag_w-1:0] commit_tag;
    logic                 wake_valid;
    logic [rob_tag_w-1:0] wake_tag;
    logic [xlen-1:0]      wake_data;
    logic                 full;
    logic                 load_done;
    logic                 store_done;
    logic [rob_tag_w-1:0] done_tag;
    logic [xlen-1:0]      load_data;

    // reference model of program order queue and memory image
    logic [4:0]  q_tag [$];
    bit          q_store [$];
    logic [5:0]  q_addr [$];
    logic [31:0] q_data [$];
    int          q_cyc [$];
    logic [31:0] model_mem [64];
    logic [31:0] live;
    logic [31:0] waiting;
    logic [31:0] commit_seen;
    logic [4:0]  dep_of [32];

    // expectation for the completion in the current cycle
    bit          chk_have;
    logic [4:0]  chk_tag;
    bit          chk_store;
    logic [31:0] chk_data;
    int          chk_lat;
    int          chk_gap;
    int          last_done = -100;
    bit          drop_expected;
    int          cyc = 0;
    int          fails [6];

    lsq_top u_lsq_top (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .dispatch     (dispatch),
        .insn_in      (insn_in),
        .commit_store (commit_store),
        .commit_tag   (commit_tag),
        .wake_valid   (wake_valid),
        .wake_tag     (wake_tag),
        .wake_data    (wake_data),
        .full         (full),
        .load_done    (load_done),
        .store_done   (store_done),
        .done_tag     (done_tag),
        .load_data    (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic note_fail(input int id, input string msg);
        fails[id]++;
        $display("ERR %0t: %s", $time, msg);
    endtask

    function automatic int fail_total();
        int sum;
        sum = 0;
        foreach (fails[i]) sum += fails[i];
        return sum;
    endfunction

    task automatic print_counts();
        $display("errors order %0d commit %0d wake %0d latency %0d full %0d flush %0d total %0d",
                 fails[0], fails[1], fails[2], fails[3], fails[4], fails[5], fail_total());
    endtask

    // word index is base plus sign extended immediate modulo 64
    function automatic logic [5:0] word_of(input logic [31:0] base, input logic [11:0] imm);
        logic [31:0] sum;
        sum = base + {{20{imm[11]}}, imm};
        return sum[5:0];
    endfunction

    function automatic logic [4:0] pick_tag();
        logic [4:0] t;
        t = 5'($urandom_range(0, 23));
        while (live[t]) begin
            t = 5'($urandom_range(0, 23));
        end
        return t;
    endfunction

    // pop the model mid cycle on every completion while outputs are stable
    always @(negedge clk) begin
        if (!rst && (load_done || store_done)) begin
            chk_have  = q_tag.size() != 0;
            chk_gap   = cyc - last_done;
            last_done = cyc;
            if (chk_have) begin
                chk_tag   = q_tag.pop_front();
                chk_store = q_store.pop_front();
                chk_data  = model_mem[q_addr[0]];
                chk_lat   = cyc - q_cyc.pop_front();
                if (chk_store) begin
                    model_mem[q_addr[0]] = q_data[0];
                end
                void'(q_addr.pop_front());
                void'(q_data.pop_front());
                live[chk_tag] = 1'b0;
            end
        end
    end

    a_order: assert property (@(posedge clk) disable iff (rst)
        (load_done || store_done) |-> chk_have && done_tag == chk_tag &&
        store_done == chk_store)
        else note_fail(0, $sformatf("completion tag %0d out of order", $sampled(done_tag)));

    a_load_data: assert property (@(posedge clk) disable iff (rst)
        load_done |-> load_data == chk_data)
        else note_fail(0, $sformatf("load tag %0d data %h, expected %h",
                       $sampled(done_tag), $sampled(load_data), chk_data));

    a_commit: assert property (@(posedge clk) disable iff (rst)
        store_done |-> commit_seen[done_tag])
        else note_fail(1, $sformatf("store tag %0d done before commit", $sampled(done_tag)));

    a_wake: assert property (@(posedge clk) disable iff (rst)
        (load_done || store_done) |-> !waiting[done_tag])
        else note_fail(2, $sformatf("tag %0d done before its broadcast", $sampled(done_tag)));

    a_latency: assert property (@(posedge clk) disable iff (rst)
        (load_done || store_done) && chk_have |-> chk_lat >= 3 && chk_gap >= 3)
        else note_fail(3, $sformatf("latency %0d, gap %0d cycles", chk_lat, chk_gap));

    a_full: assert property (@(posedge clk) disable iff (rst)
        dispatch && drop_expected |-> full)
        else note_fail(4, "full low with every slot taken");

    a_reset: assert property (@(posedge clk)
        $past(rst) |-> !(load_done || store_done || full || u_lsq_top.u_issue_if.issue ||
        u_lsq_top.u_issue_if.busy || u_lsq_top.u_issue_if.done))
        else note_fail(5, "strobe or full high right after reset");

    // stage 1 is cancelled so nothing completes in the cycle after a flush
    a_flush: assert property (@(posedge clk) disable iff (rst)
        $past(flush) |-> !(load_done || store_done))
        else note_fail(5, "completion right after flush");

    // wait_src bit 0 waits on the base and bit 1 on the store data
    // base and data are the values the op ends up with after wakeup
    task automatic send_op(
        input  ls_func_e    func,
        input  logic [31:0] base,
        input  logic [11:0] imm,
        input  logic [31:0] data,
        input  logic [1:0]  wait_src,
        input  logic [4:0]  prod,
        input  bit          commit_now,
        output logic [4:0]  tag
    );
        ls_insn_t insn;
        bit       drop;
        @(posedge clk);
        #1;
        tag             = pick_tag();
        drop            = q_tag.size() >= depth;
        insn            = '0;
        insn.insn_tag   = tag;
        insn.func       = func;
        insn.imm        = imm;
        insn.ready_src1 = !wait_src[0];
        insn.tag_src1   = wait_src[0] ? prod : 5'd0;
        insn.value_src1 = wait_src[0] ? $urandom : base;
        insn.ready_src2 = !wait_src[1];
        insn.tag_src2   = wait_src[1] ? prod : 5'd0;
        insn.value_src2 = wait_src[1] ? $urandom : data;
        insn_in         = insn;
        dispatch        = 1'b1;
        drop_expected   = drop;
        if (!drop) begin
            commit_seen[tag] = commit_now;
            commit_store     = commit_now;
            commit_tag       = tag;
            live[tag]        = 1'b1;
            waiting[tag]     = wait_src != 2'b00;
            dep_of[tag]      = prod;
            q_tag.push_back(tag);
            q_store.push_back(func == ls_store);
            q_addr.push_back(word_of(base, imm));
            q_data.push_back(data);
            q_cyc.push_back(cyc);
        end
        @(posedge clk);
        #1;
        dispatch      = 1'b0;
        commit_store  = 1'b0;
        drop_expected = 1'b0;
    endtask

    task automatic commit(input logic [4:0] tag);
        @(posedge clk);
        #1;
        commit_store     = 1'b1;
        commit_tag       = tag;
        commit_seen[tag] = 1'b1;
        @(posedge clk);
        #1;
        commit_store = 1'b0;
    endtask

    task automatic wake(input logic [4:0] prod, input logic [31:0] value);
        @(posedge clk);
        #1;
        wake_valid = 1'b1;
        wake_tag   = prod;
        wake_data  = value;
        for (int t = 0; t < 32; t++) begin
            if (live[t] && dep_of[t] == prod) waiting[t] = 1'b0;
        end
        @(posedge clk);
        #1;
        wake_valid = 1'b0;
    endtask

    task automatic flush_queue();
        @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        // a stage 2 op already left the model in the flush cycle
        q_tag.delete();
        q_store.delete();
        q_addr.delete();
        q_data.delete();
        q_cyc.delete();
        live    = '0;
        waiting = '0;
    endtask

    // ready op aimed at words 0..7 so loads hit earlier stores
    task automatic random_op(input bit allow_late);
        ls_func_e    f;
        logic [11:0] imm;
        logic [31:0] base;
        logic [4:0]  tag;
        bit          late;
        f    = ($urandom_range(0, 1) == 1) ? ls_store : ls_load;
        imm  = 12'($urandom);
        base = 32'($urandom_range(0, 7)) - {{20{imm[11]}}, imm} + ($urandom << 6);
        late = allow_late && f == ls_store && $urandom_range(0, 1) == 1;
        send_op(f, base, imm, $urandom, 2'b00, 5'd0, f == ls_store && !late, tag);
        if (late) commit(tag);
    endtask

    task automatic drain();
        while (q_tag.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    initial begin
        wait (cyc >= cycle_limit);
        $display("run timed out after %0d cycles with ops still pending", cyc);
        print_counts();
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [4:0]  tag;
        logic [4:0]  held [$];
        logic [31:0] vb;
        logic [31:0] vc;
        void'($urandom(32'h5ef5_247d));
        rst           = 1'b1;
        flush         = 1'b0;
        dispatch      = 1'b0;
        insn_in       = '0;
        commit_store  = 1'b0;
        commit_tag    = '0;
        wake_valid    = 1'b0;
        wake_tag      = '0;
        wake_data     = '0;
        drop_expected = 1'b0;
        live          = '0;
        waiting       = '0;
        commit_seen   = '0;
        for (int i = 0; i < 64; i++) model_mem[i] = '0;
        for (int i = 0; i < 32; i++) dep_of[i] = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < n_rand; i++) random_op(1'b1);
        drain();

        // store behind a stalled load gets its commit early
        send_op(ls_load, 32'h10, 12'h004, 32'd0, 2'b01, 5'd28, 1'b0, tag);
        send_op(ls_store, 32'h20, 12'hffc, 32'hc0de_0001, 2'b00, 5'd0, 1'b0, tag);
        repeat (4) @(posedge clk);
        commit(tag);
        repeat (4) @(posedge clk);
        wake(5'd28, 32'h10);
        drain();
        // uncommitted store at the head must wait
        send_op(ls_store, 32'h8, 12'h000, 32'h5a5a_0002, 2'b00, 5'd0, 1'b0, tag);
        repeat (6) @(posedge clk);
        commit(tag);
        drain();

        // one broadcast feeds base and data of the same store
        vb = $urandom;
        vc = $urandom;
        send_op(ls_load, 32'h33, 12'h001, 32'd0, 2'b01, 5'd24, 1'b0, tag);
        send_op(ls_store, vb, 12'h010, vb, 2'b11, 5'd25, 1'b1, tag);
        send_op(ls_load, vb, 12'h010, 32'd0, 2'b00, 5'd0, 1'b0, tag);
        send_op(ls_store, 32'h3, 12'h002, vc, 2'b10, 5'd26, 1'b1, tag);
        send_op(ls_load, 32'h3, 12'h002, 32'd0, 2'b00, 5'd0, 1'b0, tag);
        repeat (5) @(posedge clk);
        wake(5'd27, $urandom);
        wake(5'd25, vb);
        wake(5'd26, vc);
        wake(5'd24, 32'h33);
        drain();

        // fill with uncommitted stores so one more dispatch is dropped
        for (int i = 0; i < depth; i++) begin
            send_op(ls_store, 32'(i), 12'h000, $urandom, 2'b00, 5'd0, 1'b0, tag);
            held.push_back(tag);
        end
        send_op(ls_load, 32'h0, 12'h000, 32'd0, 2'b00, 5'd0, 1'b0, tag);
        repeat (3) @(posedge clk);
        foreach (held[i]) commit(held[i]);
        drain();

        // flush at varying depth into the unit pipeline
        for (int d = 0; d < 4; d++) begin
            for (int i = 0; i < 3; i++) random_op(1'b0);
            repeat (d) @(posedge clk);
            flush_queue();
            repeat (3) @(posedge clk);
        end

        for (int i = 0; i < 4; i++) random_op(1'b0);
        drain();

        print_counts();
        if (fail_total() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tb.f */
logic/lsq_pkg.sv
logic/lsq_issue_if.sv
logic/ls_queue.sv
logic/ls_unit.sv
logic/data_mem.sv
logic/lsq_top.sv
dv/tb_lsq.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lsq
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

# build, run, and pass only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
